// ==== branch_decode.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_if.sv
hdl/decoder_2ri16.sv
hdl/fetch_unit.sv
hdl/instr_buffer.sv
hdl/decode_stage.sv
hdl/branch_decode_top.sv
test/branch_decode_asserts.sv
test/branch_decode_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := branch_decode_tb
FILELIST  := branch_decode.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/branch_decode_tb.sv ====
`include "branch_decode_config.svh"

`default_nettype none

module branch_decode_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int NUM_WORDS = 300;
    localparam int W = `BD_DATA_WIDTH;
    localparam int AW = $clog2(`BD_GPR_NUM);
    localparam logic [5:0] BR_OPS [7] = '{6'h13, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b};

    logic            clk_i;
    logic            rst_i;
    logic            instr_req_i;
    logic [W-1:0]    instr_i;
    logic            instr_ack_o;
    logic            dec_req_o;
    logic            dec_ack_i;
    logic            dec_valid_o;
    alu_op_e         dec_aluop_o;
    alu_sel_e        dec_alusel_o;
    logic [1:0]      dec_read_valid_o;
    logic [2*AW-1:0] dec_read_addr_o;
    logic            dec_write_valid_o;
    logic [AW-1:0]   dec_write_addr_o;
    logic [W-1:0]    dec_imm_o;
    logic [W-1:0]    dec_target_o;

    // model queue of {pc, word} in send order
    logic [2*W-1:0] exp_q [$];
    int             received;
    int             offered;
    logic           dec_req_q;
    bit             run_done;
    bit             fail_shown;

    branch_decode_top DUT (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .instr_req_i       (instr_req_i),
        .instr_i           (instr_i),
        .instr_ack_o       (instr_ack_o),
        .dec_req_o         (dec_req_o),
        .dec_ack_i         (dec_ack_i),
        .dec_valid_o       (dec_valid_o),
        .dec_aluop_o       (dec_aluop_o),
        .dec_alusel_o      (dec_alusel_o),
        .dec_read_valid_o  (dec_read_valid_o),
        .dec_read_addr_o   (dec_read_addr_o),
        .dec_write_valid_o (dec_write_valid_o),
        .dec_write_addr_o  (dec_write_addr_o),
        .dec_imm_o         (dec_imm_o),
        .dec_target_o      (dec_target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // every rising dec_req_o, counted apart from the receiver
    always @(posedge clk_i) begin
        dec_req_q <= dec_req_o;
        if (!rst_i && dec_req_o && !dec_req_q) offered++;
    end

    task automatic fail_run(string why);
        $display("%s", why);
        fail_shown = 1'b1;
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(string name, logic [W-1:0] exp, logic [W-1:0] act);
        assert (exp === act)
        else fail_run($sformatf("Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    function automatic bit is_branch_op(logic [5:0] op);
        return op == 6'h13 || (op >= 6'h16 && op <= 6'h1b);
    endfunction

    // about 70 percent 2RI16 branches and other opcodes for the rest
    function automatic logic [W-1:0] gen_word();
        logic [5:0] op;
        if ($urandom_range(99) < 70) begin
            op = BR_OPS[$urandom_range(6)];
        end else begin
            do op = 6'($urandom_range(63)); while (is_branch_op(op));
        end
        return {op, 26'($urandom)};
    endfunction

    task automatic check_record(int idx, logic [W-1:0] pc, logic [W-1:0] word);
        logic [5:0]    op;
        logic [AW-1:0] rd;
        logic [AW-1:0] rj;
        logic [W-1:0]  imm;
        bit            jirl;
        bit            cond;
        alu_op_e       aluop;
        string         tag;
        op = word[31:26];
        rd = word[4:0];
        rj = word[9:5];
        imm = W'($signed(word[25:10])) << 2;
        jirl = (op == 6'h13);
        cond = is_branch_op(op) && !jirl;
        case (op)
            6'h13:   aluop = ALU_JIRL;
            6'h16:   aluop = ALU_BEQ;
            6'h17:   aluop = ALU_BNE;
            6'h18:   aluop = ALU_BLT;
            6'h19:   aluop = ALU_BGE;
            6'h1a:   aluop = ALU_BLTU;
            6'h1b:   aluop = ALU_BGEU;
            default: aluop = ALU_NOP;
        endcase
        tag = $sformatf("word %0d pc 0x%h", idx, pc);
        check_eq({tag, " valid"}, W'(jirl || cond), W'(dec_valid_o));
        check_eq({tag, " aluop"}, W'(aluop), W'(dec_aluop_o));
        check_eq({tag, " alusel"}, (jirl || cond) ? W'(SEL_JUMP) : W'(SEL_NONE),
                 W'(dec_alusel_o));
        check_eq({tag, " read valid"}, cond ? W'(2'b11) : (jirl ? W'(2'b01) : '0),
                 W'(dec_read_valid_o));
        check_eq({tag, " read addr"}, cond ? W'({rd, rj}) : (jirl ? W'(rj) : '0),
                 W'(dec_read_addr_o));
        check_eq({tag, " write valid"}, W'(jirl), W'(dec_write_valid_o));
        check_eq({tag, " write addr"}, jirl ? W'(rd) : '0, W'(dec_write_addr_o));
        check_eq({tag, " imm"}, (jirl || cond) ? imm : '0, dec_imm_o);
        // branch target or the link value for jirl
        check_eq({tag, " target"}, cond ? pc + imm : (jirl ? pc + W'(4) : '0), dec_target_o);
    endtask

    task automatic send_words();
        logic [W-1:0] pc;
        logic [W-1:0] word;
        int           i;
        pc = `BD_RESET_PC;
        for (i = 0; i < NUM_WORDS; i++) begin
            word = gen_word();
            exp_q.push_back({pc, word});
            pc = pc + W'(4);
            repeat ($urandom_range(5)) @(posedge clk_i);
            instr_i     <= word;
            instr_req_i <= 1'b1;
            do @(posedge clk_i); while (!instr_ack_o);
            instr_req_i <= 1'b0;
            do @(posedge clk_i); while (instr_ack_o);
        end
    endtask

    task automatic receive_words();
        logic [2*W-1:0] entry;
        int             delay;
        while (received < NUM_WORDS) begin
            do @(posedge clk_i); while (!dec_req_o);
            assert (exp_q.size() > 0)
            else fail_run("dec_req_o was raised with no word outstanding");
            entry = exp_q.pop_front();
            check_record(received, entry[2*W-1:W], entry[W-1:0]);
            // long stalls here fill the buffer and push back on fetch
            if (received >= 150 && received < 200) delay = 8 + $urandom_range(12);
            else delay = $urandom_range(5);
            repeat (delay) @(posedge clk_i);
            dec_ack_i <= 1'b1;
            do @(posedge clk_i); while (dec_req_o);
            dec_ack_i <= 1'b0;
            received++;
        end
    endtask

    initial begin
        void'($urandom(35));
        rst_i       = 1'b1;
        instr_req_i = 1'b0;
        instr_i     = '0;
        dec_ack_i   = 1'b0;
        received    = 0;
        offered     = 0;
        run_done    = 1'b0;
        fail_shown  = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        // both handshakes stay quiet before the first word
        repeat (4) begin
            @(posedge clk_i);
            check_eq("idle after reset instr_ack_o", '0, W'(instr_ack_o));
            check_eq("idle after reset dec_req_o", '0, W'(dec_req_o));
        end
        fork
            send_words();
            receive_words();
        join
        repeat (20) begin
            @(posedge clk_i);
            check_eq("no extra record dec_req_o", '0, W'(dec_req_o));
        end
        check_eq("record count", W'(NUM_WORDS), W'(offered));
        run_done = 1'b1;
        $display("all tests passed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_WORDS * 64) @(posedge clk_i);
        fail_run($sformatf("timeout, run not finished after %0d cycles", NUM_WORDS * 64));
    end

    // run cut short before the last check
    final begin
        if (!run_done && !fail_shown) $display("tests failed");
    end

endmodule

`default_nettype wire

// ==== test/branch_decode_asserts.sv ====
`include "branch_decode_config.svh"

`default_nettype none

module branch_decode_asserts #(
    parameter int REC_W = 2 * `BD_DATA_WIDTH + 3 * $clog2(`BD_GPR_NUM) + 15
) (
    input wire logic             clk_i,
    input wire logic             rst_i,
    input wire logic             instr_req_i,
    input wire logic             instr_ack_i,
    input wire logic             dec_req_i,
    input wire logic             dec_ack_i,
    input wire logic [REC_W-1:0] dec_rec_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // req held until its ack
    assert property (@(posedge clk_i) disable iff (rst_i)
        instr_req_i && !instr_ack_i |=> instr_req_i)
    else $error("instr_req_i dropped before instr_ack_o");

    assert property (@(posedge clk_i) disable iff (rst_i)
        dec_req_i && !dec_ack_i |=> dec_req_i)
    else $error("dec_req_o dropped before dec_ack_i");

    // ack only answers a pending req
    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(instr_ack_i) |-> instr_req_i)
    else $error("instr_ack_o rose without instr_req_i");

    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(dec_ack_i) |-> dec_req_i)
    else $error("dec_ack_i rose without dec_req_o");

    // record frozen while offered
    assert property (@(posedge clk_i) disable iff (rst_i)
        dec_req_i && $past(dec_req_i) |-> $stable(dec_rec_i))
    else $error("decoded record changed while dec_req_o was high");

    assert property (@(posedge clk_i) rst_i |=> !instr_ack_i)
    else $error("instr_ack_o high right after reset");

endmodule

bind branch_decode_top branch_decode_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_req_i (instr_req_i),
    .instr_ack_i (instr_ack_o),
    .dec_req_i   (dec_req_o),
    .dec_ack_i   (dec_ack_i),
    .dec_rec_i   ({dec_valid_o, dec_aluop_o, dec_alusel_o, dec_read_valid_o, dec_read_addr_o,
                   dec_write_valid_o, dec_write_addr_o, dec_imm_o, dec_target_o})
);

`default_nettype wire

// ==== hdl/branch_decode_top.sv ====
`include "branch_decode_config.svh"

`default_nettype none

module branch_decode_top (
    input  wire logic                              clk_i,
    input  wire logic                              rst_i,
    input  wire logic                              instr_req_i,
    input  wire logic [`BD_DATA_WIDTH-1:0]         instr_i,
    output logic                                   instr_ack_o,
    output logic                                   dec_req_o,
    input  wire logic                              dec_ack_i,
    output logic                                   dec_valid_o,
    output core_pkg::alu_op_e                      dec_aluop_o,
    output core_pkg::alu_sel_e                     dec_alusel_o,
    output logic [1:0]                             dec_read_valid_o,
    output logic [$clog2(`BD_GPR_NUM)*2-1:0]       dec_read_addr_o,
    output logic                                   dec_write_valid_o,
    output logic [$clog2(`BD_GPR_NUM)-1:0]         dec_write_addr_o,
    output logic [`BD_DATA_WIDTH-1:0]              dec_imm_o,
    output logic [`BD_DATA_WIDTH-1:0]              dec_target_o
);

    instr_if fetch_to_buf ();
    instr_if buf_to_dec ();

    fetch_unit u_fetch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .instr_ack_o (instr_ack_o),
        .out_o       (fetch_to_buf)
    );

    instr_buffer u_buffer (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .in_i  (fetch_to_buf),
        .out_o (buf_to_dec)
    );

    decode_stage u_decode (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .in_i              (buf_to_dec),
        .dec_req_o         (dec_req_o),
        .dec_ack_i         (dec_ack_i),
        .dec_valid_o       (dec_valid_o),
        .dec_aluop_o       (dec_aluop_o),
        .dec_alusel_o      (dec_alusel_o),
        .dec_read_valid_o  (dec_read_valid_o),
        .dec_read_addr_o   (dec_read_addr_o),
        .dec_write_valid_o (dec_write_valid_o),
        .dec_write_addr_o  (dec_write_addr_o),
        .dec_imm_o         (dec_imm_o),
        .dec_target_o      (dec_target_o)
    );

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`include "branch_decode_config.svh"

`default_nettype none

module decode_stage (
    input  wire logic                              clk_i,
    input  wire logic                              rst_i,
    instr_if.receiver                              in_i,
    output logic                                   dec_req_o,
    input  wire logic                              dec_ack_i,
    output logic                                   dec_valid_o,
    output core_pkg::alu_op_e                      dec_aluop_o,
    output core_pkg::alu_sel_e                     dec_alusel_o,
    output logic [1:0]                             dec_read_valid_o,
    output logic [$clog2(`BD_GPR_NUM)*2-1:0]       dec_read_addr_o,
    output logic                                   dec_write_valid_o,
    output logic [$clog2(`BD_GPR_NUM)-1:0]         dec_write_addr_o,
    output logic [`BD_DATA_WIDTH-1:0]              dec_imm_o,
    output logic [`BD_DATA_WIDTH-1:0]              dec_target_o
);
    import core_pkg::*;

    localparam int REG_AW = $clog2(`BD_GPR_NUM);

    typedef enum logic [1:0] {S_IDLE, S_RAISE, S_HOLD, S_DROP} state_e;

    state_e                    state_q;
    logic                      in_ack_q;
    logic                      capture;
    logic                      d_valid, d_write_valid;
    logic [1:0]                d_read_valid;
    logic [2*REG_AW-1:0]       d_read_addr;
    logic [REG_AW-1:0]         d_write_addr;
    logic [`BD_DATA_WIDTH-1:0] d_imm, d_target;
    alu_op_e                   d_aluop;
    alu_sel_e                  d_alusel;

    decoder_2ri16 u_decoder (
        .info_i            (in_i.info),
        .valid_o           (d_valid),
        .reg_read_valid_o  (d_read_valid),
        .reg_read_addr_o   (d_read_addr),
        .use_imm_o         (),
        .imm_o             (d_imm),
        .reg_write_valid_o (d_write_valid),
        .reg_write_addr_o  (d_write_addr),
        .aluop_o           (d_aluop),
        .alusel_o          (d_alusel)
    );

    // branch target, or link value pc+4 for jirl
    always_comb begin
        if (!d_valid) d_target = '0;
        else if (d_aluop == ALU_JIRL) d_target = in_i.info.pc + `BD_DATA_WIDTH'(4);
        else d_target = in_i.info.pc + d_imm;
    end

    assign capture = (state_q == S_IDLE) && in_i.req && !in_ack_q;

    always_ff @(posedge clk_i) begin
        if (capture) begin
            dec_valid_o       <= d_valid;
            dec_aluop_o       <= d_aluop;
            dec_alusel_o      <= d_alusel;
            dec_read_valid_o  <= d_read_valid;
            dec_read_addr_o   <= d_read_addr;
            dec_write_valid_o <= d_write_valid;
            dec_write_addr_o  <= d_write_addr;
            dec_imm_o         <= d_imm;
            dec_target_o      <= d_target;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            in_ack_q  <= 1'b0;
            dec_req_o <= 1'b0;
        end else begin
            // input side ack, released once buffer drops req
            if (capture) in_ack_q <= 1'b1;
            else if (in_ack_q && !in_i.req) in_ack_q <= 1'b0;
            case (state_q)
                S_IDLE: if (capture) state_q <= S_RAISE;
                S_RAISE: begin
                    dec_req_o <= 1'b1;
                    state_q   <= S_HOLD;
                end
                S_HOLD: if (dec_ack_i) begin
                    dec_req_o <= 1'b0;
                    state_q   <= S_DROP;
                end
                S_DROP: if (!dec_ack_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign in_i.ack = in_ack_q;

endmodule

`default_nettype wire

// ==== hdl/instr_buffer.sv ====
`include "branch_decode_config.svh"

`default_nettype none

module instr_buffer (
    input  wire logic clk_i,
    input  wire logic rst_i,
    instr_if.receiver in_i,
    instr_if.sender   out_o
);
    import core_pkg::*;

    localparam int DEPTH = `BD_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef enum logic {IN_IDLE, IN_ACK} in_state_e;
    typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT} out_state_e;

    instr_buffer_info_t mem [DEPTH];
    logic [PTR_W-1:0]   wptr_q, rptr_q;
    logic [PTR_W:0]     count_q;
    in_state_e          in_state_q;
    out_state_e         out_state_q;
    logic               in_ack_q, out_req_q;
    logic               full, push, pop;

    // back-pressure: ack is held off while full
    assign full = (count_q == (PTR_W + 1)'(DEPTH));
    assign push = (in_state_q == IN_IDLE) && in_i.req && !full;
    assign pop  = (out_state_q == OUT_REQ) && out_o.ack;

    always_ff @(posedge clk_i) begin
        if (push) mem[wptr_q] <= in_i.info;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wptr_q      <= '0;
            rptr_q      <= '0;
            count_q     <= '0;
            in_state_q  <= IN_IDLE;
            out_state_q <= OUT_IDLE;
            in_ack_q    <= 1'b0;
            out_req_q   <= 1'b0;
        end else begin
            count_q <= count_q + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
            // write side
            case (in_state_q)
                IN_IDLE: if (push) begin
                    wptr_q     <= wptr_q + 1'b1;
                    in_ack_q   <= 1'b1;
                    in_state_q <= IN_ACK;
                end
                IN_ACK: if (!in_i.req) begin
                    in_ack_q   <= 1'b0;
                    in_state_q <= IN_IDLE;
                end
                default: in_state_q <= IN_IDLE;
            endcase
            // read side
            case (out_state_q)
                OUT_IDLE: if (count_q != '0) begin
                    out_req_q   <= 1'b1;
                    out_state_q <= OUT_REQ;
                end
                OUT_REQ: if (pop) begin
                    rptr_q      <= rptr_q + 1'b1;
                    out_req_q   <= 1'b0;
                    out_state_q <= OUT_WAIT;
                end
                OUT_WAIT: if (!out_o.ack) out_state_q <= OUT_IDLE;
                default: out_state_q <= OUT_IDLE;
            endcase
        end
    end

    assign in_i.ack   = in_ack_q;
    assign out_o.req  = out_req_q;
    // head entry, rptr only moves once req is low
    assign out_o.info = mem[rptr_q];

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`include "branch_decode_config.svh"

`default_nettype none

module fetch_unit (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      instr_req_i,
    input  wire logic [`BD_DATA_WIDTH-1:0] instr_i,
    output logic                           instr_ack_o,
    instr_if.sender                        out_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {IDLE, ACK, SEND, WAIT_DROP} state_e;

    state_e                    state_q;
    logic [`BD_DATA_WIDTH-1:0] pc_q;
    instr_buffer_info_t        hold_q;
    logic                      ack_q;
    logic                      req_q;

    // holding register only changes in IDLE, out req is low there
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && instr_req_i && !ack_q) begin
            hold_q.pc    <= pc_q;
            hold_q.instr <= instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            pc_q    <= `BD_RESET_PC;
            ack_q   <= 1'b0;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (instr_req_i && !ack_q) begin
                    // tag word and step to next pc
                    pc_q    <= pc_q + `BD_DATA_WIDTH'(4);
                    ack_q   <= 1'b1;
                    state_q <= ACK;
                end
                ACK: if (!instr_req_i) begin
                    ack_q   <= 1'b0;
                    req_q   <= 1'b1;
                    state_q <= SEND;
                end
                SEND: if (out_o.ack) begin
                    req_q   <= 1'b0;
                    state_q <= WAIT_DROP;
                end
                WAIT_DROP: if (!out_o.ack) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign instr_ack_o = ack_q;
    assign out_o.req   = req_q;
    assign out_o.info  = hold_q;

endmodule

`default_nettype wire

// ==== hdl/decoder_2ri16.sv ====
`include "branch_decode_config.svh"

`default_nettype none

// 2RI16 format: {opcode[6], imm16[16], rj[5], rd[5]}
module decoder_2ri16 (
    input  core_pkg::instr_buffer_info_t             info_i,
    output logic                                     valid_o,
    output logic [1:0]                               reg_read_valid_o,
    output logic [$clog2(`BD_GPR_NUM)*2-1:0]         reg_read_addr_o,
    output logic                                     use_imm_o,
    output logic [`BD_DATA_WIDTH-1:0]                imm_o,
    output logic                                     reg_write_valid_o,
    output logic [$clog2(`BD_GPR_NUM)-1:0]           reg_write_addr_o,
    output core_pkg::alu_op_e                        aluop_o,
    output core_pkg::alu_sel_e                       alusel_o
);
    import core_pkg::*;

    localparam int REG_AW = $clog2(`BD_GPR_NUM);

    logic [REG_AW-1:0] rd, rj;
    logic [15:0]       imm16;
    opcode_e           opcode;

    assign rd     = info_i.instr[4:0];
    assign rj     = info_i.instr[9:5];
    assign imm16  = info_i.instr[25:10];
    assign opcode = opcode_e'(info_i.instr[31:26]);

    always_comb begin
        // conditional branch record as the default
        valid_o           = 1'b1;
        reg_read_valid_o  = 2'b11;
        reg_read_addr_o   = {rd, rj};
        use_imm_o         = 1'b0;
        imm_o             = {{(`BD_DATA_WIDTH - 18){imm16[15]}}, imm16, 2'b00};
        reg_write_valid_o = 1'b0;
        reg_write_addr_o  = '0;
        aluop_o           = ALU_NOP;
        alusel_o          = SEL_JUMP;
        case (opcode)
            OP_JIRL: begin
                // rj only, link goes to rd
                aluop_o           = ALU_JIRL;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {{REG_AW{1'b0}}, rj};
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
            end
            OP_BEQ:  aluop_o = ALU_BEQ;
            OP_BNE:  aluop_o = ALU_BNE;
            OP_BLT:  aluop_o = ALU_BLT;
            OP_BGE:  aluop_o = ALU_BGE;
            OP_BLTU: aluop_o = ALU_BLTU;
            OP_BGEU: aluop_o = ALU_BGEU;
            default: begin
                // not a 2RI16 branch, all zero
                valid_o           = 1'b0;
                reg_read_valid_o  = 2'b00;
                reg_read_addr_o   = '0;
                imm_o             = '0;
                reg_write_valid_o = 1'b0;
                reg_write_addr_o  = '0;
                aluop_o           = ALU_NOP;
                alusel_o          = SEL_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/instr_if.sv ====
`default_nettype none

interface instr_if;
    import core_pkg::*;

    // four-phase handshake, info stable while req is high
    logic               req;
    logic               ack;
    instr_buffer_info_t info;

    modport sender (
        output req, info,
        input  ack
    );

    modport receiver (
        input  req, info,
        output ack
    );
endinterface

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`include "branch_decode_config.svh"

`default_nettype none

package core_pkg;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_JIRL = 6'h13,
        OP_BEQ  = 6'h16,
        OP_BNE  = 6'h17,
        OP_BLT  = 6'h18,
        OP_BGE  = 6'h19,
        OP_BLTU = 6'h1a,
        OP_BGEU = 6'h1b
    } opcode_e;

    // alu operation, nop for anything not decoded
    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_JIRL = 8'h01,
        ALU_BEQ  = 8'h02,
        ALU_BNE  = 8'h03,
        ALU_BLT  = 8'h04,
        ALU_BGE  = 8'h05,
        ALU_BLTU = 8'h06,
        ALU_BGEU = 8'h07
    } alu_op_e;

    // result select
    typedef enum logic [2:0] {
        SEL_NONE = 3'd0,
        SEL_JUMP = 3'd1
    } alu_sel_e;

    // one fetched word with the pc it was fetched at
    typedef struct packed {
        logic [`BD_DATA_WIDTH-1:0] pc;
        logic [`BD_DATA_WIDTH-1:0] instr;
    } instr_buffer_info_t;

endpackage

`default_nettype wire

// ==== hdl/branch_decode_config.svh ====
`ifndef BRANCH_DECODE_CONFIG_SVH
`define BRANCH_DECODE_CONFIG_SVH

// width of instruction words, pc and immediates
`define BD_DATA_WIDTH 32

// general register count, addresses are log2 of this
`define BD_GPR_NUM 32

// instruction buffer entries, power of two and at least 2
`define BD_BUF_DEPTH 4

// pc given to the first word after reset
`define BD_RESET_PC 32'h1c00_0000

`endif
